// File: rtl/image_pkg.sv
`default_nettype none

package image_pkg;

    localparam int img_cols      = 16;
    localparam int img_rows      = 16;
    localparam int pix_bits      = 8;
    localparam int row_addr_bits = 4;
    localparam int col_bits      = 4;
    localparam int kpt_addr_bits = 8;   // 256 keypoint entries

    typedef logic [pix_bits-1:0] pixel_t;

    // one memory word holds a full image row, column c in element c
    typedef pixel_t [img_cols-1:0] img_row_t;

    typedef struct packed {
        logic [row_addr_bits-1:0] row;
        logic [col_bits-1:0]      col;
    } kpt_t;

    typedef logic [kpt_addr_bits:0] kpt_count_t;   // 0 to 256

    // keypoint memory port, same field order as a row request
    typedef struct packed {
        logic                     we;
        logic [kpt_addr_bits-1:0] addr;
        kpt_t                     data;
    } kpt_req_t;

endpackage

`default_nettype wire

// File: rtl/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

    typedef enum logic [2:0] {
        ph_idle,
        ph_gaussian,
        ph_detect,
        ph_done
    } phase_t;

    // one port request to an image or blur memory
    typedef struct packed {
        logic                                we;
        logic [image_pkg::row_addr_bits-1:0] addr;
        image_pkg::img_row_t                 data;
    } row_req_t;

endpackage

`default_nettype wire

// File: rtl/row_mem.sv
`timescale 1ns/1ns
`default_nettype none

module row_mem #(
    parameter int width      = 8,
    parameter int depth_bits = 4
) (
    input  wire logic                        clk,
    input  wire logic [width+depth_bits:0]   req,    // {we, addr, data}
    output logic      [width-1:0]            dout
);

    logic [width-1:0]      mem [2**depth_bits];
    logic                  we;
    logic [depth_bits-1:0] addr;
    logic [width-1:0]      data;

    assign we   = req[width+depth_bits];
    assign addr = req[width+depth_bits-1:width];
    assign data = req[width-1:0];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= data;
        end
        dout <= mem[addr];   // read before write
    end

endmodule

`default_nettype wire

// File: rtl/line_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module line_buffer (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 shift,
    input  wire logic                 zero_row,   // bottom border
    input  wire image_pkg::img_row_t  row_in,
    output image_pkg::img_row_t       win_top,
    output image_pkg::img_row_t       win_mid,
    output image_pkg::img_row_t       win_bot
);

    image_pkg::img_row_t new_row;

    assign new_row = zero_row ? '0 : row_in;

    // window rolls down one row per shift
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            win_top <= '0;
            win_mid <= '0;
            win_bot <= '0;
        end else if (shift) begin
            win_top <= win_mid;
            win_mid <= win_bot;
            win_bot <= new_row;
        end
    end

endmodule

`default_nettype wire

// File: rtl/gaussian_blur.sv
`timescale 1ns/1ns
`default_nettype none

module gaussian_blur (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 start,
    output logic                      done,
    output ctrl_pkg::row_req_t        img_req,
    input  wire image_pkg::img_row_t  img_dout,
    output ctrl_pkg::row_req_t        blur_req
);

    logic                                busy;
    logic                                capture;    // second cycle of a step
    logic [image_pkg::row_addr_bits:0]   step;       // 0 .. img_rows
    logic [image_pkg::row_addr_bits:0]   prev_step;
    logic                                shift;
    logic                                zero_row;
    logic                                wr_pend;
    logic [image_pkg::row_addr_bits-1:0] wr_row;
    image_pkg::img_row_t                 win_top;
    image_pkg::img_row_t                 win_mid;
    image_pkg::img_row_t                 win_bot;
    logic [9:0]                          col_sum [image_pkg::img_cols+2];
    logic [11:0]                         box_sum [image_pkg::img_cols];
    image_pkg::img_row_t                 blur_row;

    assign shift     = busy & capture;
    assign zero_row  = (step == image_pkg::img_rows);   // last step pads the bottom
    assign prev_step = step - 1'b1;

    line_buffer u_line_buffer (
        .clk      (clk),
        .rst_n    (rst_n),
        .shift    (shift),
        .zero_row (zero_row),
        .row_in   (img_dout),
        .win_top  (win_top),
        .win_mid  (win_mid),
        .win_bot  (win_bot)
    );

    // read of step 0 goes out in the start cycle, step idles at 0
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            capture <= 1'b0;
            step    <= '0;
            done    <= 1'b0;
            wr_pend <= 1'b0;
        end else begin
            done    <= 1'b0;
            wr_pend <= shift && (step != 0);   // window centered on row step-1
            if (start && !busy) begin
                busy    <= 1'b1;
                capture <= 1'b1;
                step    <= '0;
            end else if (busy) begin
                capture <= ~capture;
                if (capture) begin
                    if (zero_row) begin
                        busy <= 1'b0;
                        step <= '0;
                        done <= 1'b1;
                    end else begin
                        step <= step + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (shift) begin
            wr_row <= prev_step[image_pkg::row_addr_bits-1:0];
        end
    end

    // vertical 1-2-1, zero columns padded on both sides
    always_comb begin
        col_sum[0]                    = '0;
        col_sum[image_pkg::img_cols+1] = '0;
        for (int c = 0; c < image_pkg::img_cols; c++) begin
            col_sum[c+1] = {2'b00, win_top[c]} + {1'b0, win_mid[c], 1'b0}
                         + {2'b00, win_bot[c]};
        end
    end

    // horizontal 1-2-1 then divide by 16
    always_comb begin
        for (int c = 0; c < image_pkg::img_cols; c++) begin
            box_sum[c]  = {2'b00, col_sum[c]} + {1'b0, col_sum[c+1], 1'b0}
                        + {2'b00, col_sum[c+2]};
            blur_row[c] = box_sum[c][11:4];
        end
    end

    always_comb begin
        img_req       = '0;
        img_req.addr  = step[image_pkg::row_addr_bits-1:0];
        blur_req      = '0;
        blur_req.we   = wr_pend;
        blur_req.addr = wr_row;
        blur_req.data = blur_row;
    end

endmodule

`default_nettype wire

// File: rtl/keypoint_detect.sv
`timescale 1ns/1ns
`default_nettype none

module keypoint_detect (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 start,
    output logic                      done,
    input  wire logic                 filter_on,
    input  wire image_pkg::pixel_t    threshold,
    output ctrl_pkg::row_req_t        img_req,
    output ctrl_pkg::row_req_t        blur_req,
    input  wire image_pkg::img_row_t  img_dout,
    input  wire image_pkg::img_row_t  blur_dout,
    output image_pkg::kpt_req_t       kpt_req,
    output image_pkg::kpt_count_t     kpt_count
);

    logic                                busy;
    logic                                scan;    // low during the row read cycle
    logic [image_pkg::row_addr_bits-1:0] row;
    logic [image_pkg::col_bits-1:0]      col;
    logic signed [8:0]                   diff;
    logic [8:0]                          abs_diff;
    logic                                hit;

    assign diff     = {1'b0, img_dout[col]} - {1'b0, blur_dout[col]};
    assign abs_diff = (diff < 0) ? -diff : diff;
    assign hit      = filter_on ? (abs_diff > {1'b0, threshold}) : (diff != 0);

    // row address stays put while scanning so dout holds the row
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            scan      <= 1'b0;
            row       <= '0;
            col       <= '0;
            done      <= 1'b0;
            kpt_count <= '0;
        end else begin
            done <= 1'b0;
            if (start && !busy) begin
                busy      <= 1'b1;
                scan      <= 1'b1;   // row 0 read in the start cycle
                col       <= '0;
                kpt_count <= '0;
            end else if (busy) begin
                if (kpt_req.we) begin
                    kpt_count <= kpt_count + 1'b1;
                end
                if (!scan) begin
                    scan <= 1'b1;
                end else begin
                    col <= col + 1'b1;
                    if (&col) begin
                        scan <= 1'b0;
                        row  <= row + 1'b1;   // wraps to 0 after the last row
                        if (&row) begin
                            busy <= 1'b0;
                            done <= 1'b1;
                        end
                    end
                end
            end
        end
    end

    always_comb begin
        img_req           = '0;
        img_req.addr      = row;
        blur_req          = '0;
        blur_req.addr     = row;
        kpt_req.we        = busy & scan & hit;
        kpt_req.addr      = kpt_count[image_pkg::kpt_addr_bits-1:0];
        kpt_req.data.row  = row;
        kpt_req.data.col  = col;
    end

endmodule

`default_nettype wire

// File: rtl/sift_proc.sv
`timescale 1ns/1ns
`default_nettype none

module sift_proc (
    input  wire logic                                 clk,
    input  wire logic                                 rst_n,
    input  wire logic                                 start,
    output logic                                      done,
    input  wire logic                                 filter_on,
    input  wire image_pkg::pixel_t                    threshold,
    input  wire logic                                 img_we,
    input  wire logic [image_pkg::row_addr_bits-1:0]  img_addr,
    input  wire image_pkg::img_row_t                  img_din,
    input  wire logic [image_pkg::kpt_addr_bits-1:0]  kpt_addr,
    output image_pkg::kpt_t                           kpt_dout,
    output image_pkg::kpt_count_t                     kpt_count
);

    ctrl_pkg::phase_t    phase;
    ctrl_pkg::phase_t    phase_nxt;
    logic                gauss_start;
    logic                gauss_done;
    logic                det_start;
    logic                det_done;
    ctrl_pkg::row_req_t  gauss_img_req;
    ctrl_pkg::row_req_t  gauss_blur_req;
    ctrl_pkg::row_req_t  det_img_req;
    ctrl_pkg::row_req_t  det_blur_req;
    image_pkg::kpt_req_t det_kpt_req;
    ctrl_pkg::row_req_t  img_port;
    ctrl_pkg::row_req_t  blur_port;
    image_pkg::kpt_req_t kpt_port;
    image_pkg::img_row_t img_dout;
    image_pkg::img_row_t blur_dout;

    assign done = (phase == ctrl_pkg::ph_done);

    always_comb begin
        phase_nxt = phase;
        case (phase)
            ctrl_pkg::ph_idle,
            ctrl_pkg::ph_done:     if (start) phase_nxt = ctrl_pkg::ph_gaussian;
            ctrl_pkg::ph_gaussian: if (gauss_done) phase_nxt = ctrl_pkg::ph_detect;
            ctrl_pkg::ph_detect:   if (det_done) phase_nxt = ctrl_pkg::ph_done;
            default:               phase_nxt = ctrl_pkg::ph_idle;
        endcase
    end

    // start pulses land in the first cycle of each phase
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase       <= ctrl_pkg::ph_idle;
            gauss_start <= 1'b0;
            det_start   <= 1'b0;
        end else begin
            phase       <= phase_nxt;
            gauss_start <= (phase_nxt == ctrl_pkg::ph_gaussian) &&
                           (phase != ctrl_pkg::ph_gaussian);
            det_start   <= (phase_nxt == ctrl_pkg::ph_detect) &&
                           (phase != ctrl_pkg::ph_detect);
        end
    end

    always_comb begin
        img_port  = '{we: img_we, addr: img_addr, data: img_din};
        blur_port = '0;
        kpt_port  = '{we: 1'b0, addr: kpt_addr, data: '0};
        case (phase)
            ctrl_pkg::ph_gaussian: begin
                img_port    = gauss_img_req;
                img_port.we = 1'b0;   // image is read only here
                blur_port   = gauss_blur_req;
            end
            ctrl_pkg::ph_detect: begin
                img_port  = det_img_req;
                blur_port = det_blur_req;
                kpt_port  = det_kpt_req;
            end
            default: ;
        endcase
    end

    row_mem #(
        .width      ($bits(image_pkg::img_row_t)),
        .depth_bits (image_pkg::row_addr_bits)
    ) img_mem (
        .clk  (clk),
        .req  (img_port),
        .dout (img_dout)
    );

    row_mem #(
        .width      ($bits(image_pkg::img_row_t)),
        .depth_bits (image_pkg::row_addr_bits)
    ) blur_mem (
        .clk  (clk),
        .req  (blur_port),
        .dout (blur_dout)
    );

    row_mem #(
        .width      ($bits(image_pkg::kpt_t)),
        .depth_bits (image_pkg::kpt_addr_bits)
    ) kpt_mem (
        .clk  (clk),
        .req  (kpt_port),
        .dout (kpt_dout)
    );

    gaussian_blur u_gaussian_blur (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (gauss_start),
        .done     (gauss_done),
        .img_req  (gauss_img_req),
        .img_dout (img_dout),
        .blur_req (gauss_blur_req)
    );

    keypoint_detect u_keypoint_detect (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (det_start),
        .done      (det_done),
        .filter_on (filter_on),
        .threshold (threshold),
        .img_req   (det_img_req),
        .blur_req  (det_blur_req),
        .img_dout  (img_dout),
        .blur_dout (blur_dout),
        .kpt_req   (det_kpt_req),
        .kpt_count (kpt_count)
    );

endmodule

`default_nettype wire

// File: testbench/sift_proc_properties.sv
`timescale 1ns/1ns
`default_nettype none

module sift_proc_props (
    input wire logic                  clk,
    input wire logic                  rst_n,
    input wire logic                  start,
    input wire logic                  done,
    input wire image_pkg::kpt_count_t kpt_count
);

    logic armed;   // start seen since the last done

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            armed <= 1'b0;
        end else if (start) begin
            armed <= 1'b1;
        end else if (done) begin
            armed <= 1'b0;
        end
    end

    a_reset_clear: assert property (@(posedge clk)
        $rose(rst_n) |-> (!done && kpt_count == '0))
        else $error("done or keypoint count not clear after reset");

    a_count_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (done && $past(done)) |-> $stable(kpt_count))
        else $error("keypoint count changed while done was high");

    a_done_after_start: assert property (@(posedge clk) disable iff (!rst_n)
        (done && !$past(done)) |-> armed)
        else $error("done rose without a preceding start");

endmodule

`default_nettype wire

// File: testbench/tb_sift_proc.sv
`timescale 1ns/1ns
`default_nettype none

module tb_sift_proc;

    localparam int clk_period   = 10;
    localparam int num_runs     = 4;
    localparam int run_cycles   = 400;
    localparam int load_cycles  = 2 * image_pkg::img_rows + 4;
    localparam int read_cycles  = 2 * (1 << image_pkg::kpt_addr_bits) + 4;
    localparam int limit_cycles = 10 + num_runs * (run_cycles + load_cycles + read_cycles);

    logic                                clk;
    logic                                rst_n;
    logic                                start;
    logic                                done;
    logic                                filter_on;
    image_pkg::pixel_t                   threshold;
    logic                                img_we;
    logic [image_pkg::row_addr_bits-1:0] img_addr;
    image_pkg::img_row_t                 img_din;
    logic [image_pkg::kpt_addr_bits-1:0] kpt_addr;
    image_pkg::kpt_t                     kpt_dout;
    image_pkg::kpt_count_t               kpt_count;

    logic [15:0]       lfsr_state;
    image_pkg::pixel_t pix [image_pkg::img_rows][image_pkg::img_cols];
    image_pkg::kpt_t   exp_kpts [$];
    image_pkg::kpt_t   got_kpts [$];
    image_pkg::kpt_t   prev_kpts [$];

    sift_proc uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .done      (done),
        .filter_on (filter_on),
        .threshold (threshold),
        .img_we    (img_we),
        .img_addr  (img_addr),
        .img_din   (img_din),
        .kpt_addr  (kpt_addr),
        .kpt_dout  (kpt_dout),
        .kpt_count (kpt_count)
    );

    bind sift_proc sift_proc_props u_props (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .done      (done),
        .kpt_count (kpt_count)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        assert (actual == expected) else begin
            stop_with_error($sformatf("FAILED at %0t: %s expected %0d, got %0d",
                                      $time, name, expected, actual));
        end
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic image_pkg::pixel_t random_pixel();
        image_pkg::pixel_t p;
        p = '0;
        for (int b = 0; b < image_pkg::pix_bits; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            p = {p[6:0], lfsr_state[0]};   // one step per bit
        end
        return p;
    endfunction

    task automatic fill_image(input logic flat, input int value);
        for (int r = 0; r < image_pkg::img_rows; r++) begin
            for (int c = 0; c < image_pkg::img_cols; c++) begin
                pix[r][c] = flat ? 8'(value) : random_pixel();
            end
        end
    endtask

    function automatic int pixel_at(input int r, input int c);
        if (r < 0 || r >= image_pkg::img_rows || c < 0 || c >= image_pkg::img_cols) begin
            return 0;   // zero outside the image
        end
        return int'(pix[r][c]);
    endfunction

    function automatic int blur_at(input int r, input int c);
        int sum;
        sum = 0;
        for (int dr = -1; dr <= 1; dr++) begin
            for (int dc = -1; dc <= 1; dc++) begin
                sum += (dr == 0 ? 2 : 1) * (dc == 0 ? 2 : 1) * pixel_at(r + dr, c + dc);
            end
        end
        return sum / 16;
    endfunction

    task automatic build_expected(input logic filter, input int thr);
        int              d;
        image_pkg::kpt_t k;
        exp_kpts.delete();
        for (int r = 0; r < image_pkg::img_rows; r++) begin
            for (int c = 0; c < image_pkg::img_cols; c++) begin
                d = pixel_at(r, c) - blur_at(r, c);
                if (filter ? (d > thr || -d > thr) : (d != 0)) begin
                    k.row = 4'(r);
                    k.col = 4'(c);
                    exp_kpts.push_back(k);   // raster order
                end
            end
        end
    endtask

    task automatic load_image();
        image_pkg::img_row_t word;
        for (int r = 0; r < image_pkg::img_rows; r++) begin
            for (int c = 0; c < image_pkg::img_cols; c++) begin
                word[c] = pix[r][c];
            end
            @(posedge clk);
            img_we   <= 1'b1;
            img_addr <= 4'(r);
            img_din  <= word;
        end
        @(posedge clk);
        img_we <= 1'b0;
    endtask

    // reads back as many entries as the DUT reports, capped at the memory depth
    task automatic run_and_read(input logic filter, input image_pkg::pixel_t thr);
        int n;
        @(posedge clk);
        filter_on <= filter;
        threshold <= thr;
        start     <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        while (!done) begin
            @(negedge clk);
        end
        n = int'(kpt_count);
        if (n > (1 << image_pkg::kpt_addr_bits)) begin
            n = 1 << image_pkg::kpt_addr_bits;
        end
        got_kpts.delete();
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            kpt_addr <= 8'(i);
            @(posedge clk);
            @(negedge clk);   // registered read settled
            got_kpts.push_back(kpt_dout);
        end
    endtask

    task automatic compare_with_model(input logic filter, input image_pkg::pixel_t thr);
        build_expected(filter, int'(thr));
        check_value("kpt_count", exp_kpts.size(), int'(kpt_count));
        foreach (exp_kpts[i]) begin
            check_value($sformatf("kpt_dout[%0d]", i), int'(exp_kpts[i]),
                        int'(got_kpts[i]));
        end
    endtask

    task automatic check_border();
        logic edge_pix;
        foreach (got_kpts[i]) begin
            edge_pix = (got_kpts[i].row == 0) || (got_kpts[i].row == 15) ||
                       (got_kpts[i].col == 0) || (got_kpts[i].col == 15);
            assert (edge_pix) else begin
                stop_with_error("flat image gave a keypoint away from the border");
            end
        end
    endtask

    task automatic check_subset();
        logic found;
        foreach (got_kpts[i]) begin
            found = 1'b0;
            foreach (prev_kpts[j]) begin
                if (prev_kpts[j] == got_kpts[i]) begin
                    found = 1'b1;
                end
            end
            assert (found) else begin
                stop_with_error("filtered keypoint missing from the unfiltered list");
            end
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        start      = 1'b0;
        filter_on  = 1'b0;
        threshold  = '0;
        img_we     = 1'b0;
        img_addr   = '0;
        img_din    = '0;
        kpt_addr   = '0;
        lfsr_state = 16'd29;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("done", 0, int'(done));
        check_value("kpt_count", 0, int'(kpt_count));

        fill_image(1'b1, 100);
        load_image();
        run_and_read(1'b0, 8'd0);
        check_border();
        compare_with_model(1'b0, 8'd0);

        fill_image(1'b0, 0);
        load_image();
        run_and_read(1'b0, 8'd0);
        compare_with_model(1'b0, 8'd0);
        prev_kpts = got_kpts;

        run_and_read(1'b1, 8'd20);   // same image, filtered
        check_subset();
        compare_with_model(1'b1, 8'd20);

        fill_image(1'b0, 0);
        load_image();
        run_and_read(1'b0, 8'd0);
        compare_with_model(1'b0, 8'd0);

        $display("PASS: all tests");
        $finish;
    end

    initial begin
        #(limit_cycles * clk_period);
        stop_with_error("timeout: the run did not reach done in time");
    end

endmodule

`default_nettype wire

// File: all.f
rtl/image_pkg.sv
rtl/ctrl_pkg.sv
rtl/row_mem.sv
rtl/line_buffer.sv
rtl/gaussian_blur.sv
rtl/keypoint_detect.sv
rtl/sift_proc.sv
testbench/sift_proc_properties.sv
testbench/tb_sift_proc.sv

// File: Makefile
TOP = tb_sift_proc

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f all.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f all.f -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
